// File: hdl/dcache_pkg.sv
package dcache_pkg;

	// Size of one load/store access
	typedef enum logic [1:0] {
		ORDER_BYTE = 2'd0,
		ORDER_HALF = 2'd1,
		ORDER_WORD = 2'd2
	} access_order_t;

	// Controller FSM states
	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		REFILL_REQ,
		REFILL_GET,
		RD_OUT,
		WR_REQ,
		WR_WAIT,
		WR_OUT
	} ctrl_state_t;

	// Line geometry, 64 bytes moved as 64-bit beats
	localparam int LINE_BEATS  = 8;
	localparam int OFFSET_BITS = 6;
	localparam int BEAT_BITS   = $clog2(LINE_BEATS);

	// Associativity
	localparam int WAYS        = 4;
	localparam int WAY_BITS    = $clog2(WAYS);

endpackage

// File: hdl/dcache_ldst_if.sv
`timescale 1ns/10ps

interface dcache_ldst_if
	import dcache_pkg::*;
();

	// Request side, held until req && !busy
	logic			req;
	logic			rw;		// 0 write, 1 read
	access_order_t	order;
	logic [31:0]	addr;
	logic [31:0]	wdata;

	// Response side
	logic			busy;
	logic			valid;
	logic [31:0]	rdata;

	modport router (
		output	req, rw, order, addr, wdata,
		input	busy, valid, rdata
	);

	modport cache (
		input	req, rw, order, addr, wdata,
		output	busy, valid, rdata
	);

endinterface

// File: hdl/dcache_array_if.sv
`timescale 1ns/10ps

interface dcache_array_if
	import dcache_pkg::*;
();

	// Controller state, seen by the array checks
	ctrl_state_t			state;
	// Lookup, answered one cycle later
	logic					lookup_req;
	logic [31:0]			lookup_addr;
	logic					lookup_valid;
	logic					lookup_hit;
	logic [31:0]			lookup_data;
	// Line fill, one beat per strobe
	logic					fill_req;
	logic [31:0]			fill_addr;
	logic [BEAT_BITS-1:0]	fill_beat;
	logic [63:0]			fill_data;
	// Write-through update, data right-justified
	logic					store_req;
	logic [31:0]			store_addr;
	access_order_t			store_order;
	logic [31:0]			store_data;
	logic					flush;

	modport ctrl (
		output	state, lookup_req, lookup_addr, fill_req, fill_addr, fill_beat, fill_data,
		output	store_req, store_addr, store_order, store_data, flush,
		input	lookup_valid, lookup_hit, lookup_data
	);

	modport array (
		input	state, lookup_req, lookup_addr, fill_req, fill_addr, fill_beat, fill_data,
		input	store_req, store_addr, store_order, store_data, flush,
		output	lookup_valid, lookup_hit, lookup_data
	);

endinterface

// File: hdl/io_window_router.sv
`timescale 1ns/10ps

module io_window_router
	import dcache_pkg::*;
(
	input	logic			iCLOCK,
	input	logic			inRESET,
	input	logic			iosr_valid,
	input	logic [31:0]	iosr_base,
	// Load/store unit
	input	logic			ldst_req,
	input	logic			ldst_rw,
	input	access_order_t	ldst_order,
	input	logic [31:0]	ldst_addr,
	input	logic [31:0]	ldst_wdata,
	output	logic			ldst_busy,
	output	logic			ldst_valid,
	output	logic [31:0]	ldst_rdata,
	// I/O bus
	output	logic			io_req,
	output	logic			io_rw,
	output	access_order_t	io_order,
	output	logic [31:0]	io_addr,
	output	logic [31:0]	io_wdata,
	input	logic			io_busy,
	input	logic			io_valid,
	input	logic [31:0]	io_rdata,
	// Cache controller
	dcache_ldst_if.router	cache
);

	logic			io_base_valid;
	logic [31:0]	io_base;
	logic			io_pending;
	logic			to_io;
	logic			io_accept;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			io_base_valid	<= 1'b0;
			io_pending		<= 1'b0;
		end else begin
			if (iosr_valid) begin
				io_base_valid <= 1'b1;
			end
			// One I/O access in flight until its response
			if (io_accept && !io_valid) begin
				io_pending <= 1'b1;
			end else if (io_valid) begin
				io_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (iosr_valid) begin
			io_base <= iosr_base;
		end
	end

	// Window starts at the base and runs to the top of the address space
	assign to_io		= io_base_valid && (ldst_addr >= io_base);
	assign io_req		= ldst_req && to_io && !io_pending && !cache.busy;
	assign io_accept	= io_req && !io_busy;
	assign io_rw		= ldst_rw;
	assign io_order		= ldst_order;
	assign io_addr		= ldst_addr - io_base;
	assign io_wdata		= ldst_wdata;

	assign cache.req	= ldst_req && !to_io && !io_pending && !io_busy;
	assign cache.rw		= ldst_rw;
	assign cache.order	= ldst_order;
	assign cache.addr	= ldst_addr;
	assign cache.wdata	= ldst_wdata;

	assign ldst_busy	= cache.busy || io_pending || io_busy;
	assign ldst_valid	= io_valid || cache.valid;
	assign ldst_rdata	= io_valid ? io_rdata : cache.rdata;

endmodule

// File: hdl/dcache_array.sv
`timescale 1ns/10ps

module dcache_array
	import dcache_pkg::*;
#(
	parameter int NUM_SETS = 16
) (
	input	logic			iCLOCK,
	input	logic			inRESET,
	dcache_array_if.array	arr
);

	localparam int INDEX_BITS	= $clog2(NUM_SETS);
	localparam int TAG_BITS		= 32 - OFFSET_BITS - INDEX_BITS;

	logic [TAG_BITS-1:0]	tag_mem [NUM_SETS][WAYS];
	logic [63:0]			data_mem [NUM_SETS][WAYS][LINE_BEATS];
	logic [WAYS-1:0]		valid_q [NUM_SETS];
	logic [2:0]				plru_q [NUM_SETS];
	logic [WAY_BITS-1:0]	fill_way_q;

	logic [INDEX_BITS-1:0]	lk_idx;
	logic [WAYS-1:0]		lk_match;
	logic [WAY_BITS-1:0]	lk_way;
	logic [63:0]			lk_beat;
	logic [INDEX_BITS-1:0]	fl_idx;
	logic [WAY_BITS-1:0]	fl_way;
	logic [INDEX_BITS-1:0]	st_idx;
	logic [WAYS-1:0]		st_match;
	logic [WAY_BITS-1:0]	st_way;
	logic [BEAT_BITS-1:0]	st_beat;
	logic [2:0]				st_off;
	logic [7:0]				st_be;
	logic [63:0]			st_wide;

	function automatic logic [WAYS-1:0] match_ways(input logic [31:0] addr);
		logic [INDEX_BITS-1:0]	idx;
		logic [WAYS-1:0]		m;
		idx = addr[OFFSET_BITS +: INDEX_BITS];
		for (int w = 0; w < WAYS; w++) begin
			m[w] = valid_q[idx][w] && (tag_mem[idx][w] == addr[31 -: TAG_BITS]);
		end
		return m;
	endfunction

	// Lowest set bit wins
	function automatic logic [WAY_BITS-1:0] way_of(input logic [WAYS-1:0] m);
		logic [WAY_BITS-1:0] w;
		w = '0;
		for (int i = WAYS - 1; i >= 0; i--) begin
			if (m[i]) begin
				w = WAY_BITS'(i);
			end
		end
		return w;
	endfunction

	// Tree bits: [0] root, [1] ways 0/1, [2] ways 2/3; each points at the older side
	function automatic logic [WAY_BITS-1:0] plru_victim(input logic [2:0] t);
		return t[0] ? {1'b1, t[2]} : {1'b0, t[1]};
	endfunction

	function automatic logic [2:0] plru_touch(input logic [2:0] t, input logic [WAY_BITS-1:0] w);
		logic [2:0] n;
		n = t;
		n[0] = ~w[1];
		if (w[1]) begin
			n[2] = ~w[0];
		end else begin
			n[1] = ~w[0];
		end
		return n;
	endfunction

	always_comb begin
		lk_idx		= arr.lookup_addr[OFFSET_BITS +: INDEX_BITS];
		lk_match	= match_ways(arr.lookup_addr);
		lk_way		= way_of(lk_match);
		lk_beat		= data_mem[lk_idx][lk_way][arr.lookup_addr[OFFSET_BITS-1:3]];

		// Victim is picked on beat 0 and held for the rest of the burst
		fl_idx = arr.fill_addr[OFFSET_BITS +: INDEX_BITS];
		if (arr.fill_beat != '0) begin
			fl_way = fill_way_q;
		end else if (&valid_q[fl_idx]) begin
			fl_way = plru_victim(plru_q[fl_idx]);
		end else begin
			fl_way = way_of(~valid_q[fl_idx]);
		end

		st_idx		= arr.store_addr[OFFSET_BITS +: INDEX_BITS];
		st_match	= match_ways(arr.store_addr);
		st_way		= way_of(st_match);
		st_beat		= arr.store_addr[OFFSET_BITS-1:3];
		st_off		= arr.store_addr[2:0];
		// Replicate store data across the beat, byte enables pick the lanes
		case (arr.store_order)
			ORDER_BYTE: begin
				st_be	= 8'b0000_0001 << st_off;
				st_wide	= {8{arr.store_data[7:0]}};
			end
			ORDER_HALF: begin
				st_be	= 8'b0000_0011 << {st_off[2:1], 1'b0};
				st_wide	= {4{arr.store_data[15:0]}};
			end
			default: begin
				st_be	= 8'b0000_1111 << {st_off[2], 2'b00};
				st_wide	= {2{arr.store_data}};
			end
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			arr.lookup_valid	<= 1'b0;
			arr.lookup_hit		<= 1'b0;
			fill_way_q			<= '0;
			for (int s = 0; s < NUM_SETS; s++) begin
				valid_q[s]	<= '0;
				plru_q[s]	<= '0;
			end
		end else begin
			arr.lookup_valid	<= arr.lookup_req;
			arr.lookup_hit		<= arr.lookup_req && (|lk_match);
			if (arr.lookup_req && (|lk_match)) begin
				plru_q[lk_idx] <= plru_touch(plru_q[lk_idx], lk_way);
			end
			if (arr.fill_req && (arr.fill_beat == '0)) begin
				fill_way_q				<= fl_way;
				valid_q[fl_idx][fl_way]	<= 1'b0;
			end
			// Line becomes visible only once the last beat is in
			if (arr.fill_req && (arr.fill_beat == BEAT_BITS'(LINE_BEATS - 1))) begin
				valid_q[fl_idx][fl_way]	<= 1'b1;
				plru_q[fl_idx]			<= plru_touch(plru_q[fl_idx], fl_way);
			end
			if (arr.flush) begin
				for (int s = 0; s < NUM_SETS; s++) begin
					valid_q[s] <= '0;
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (arr.lookup_req) begin
			arr.lookup_data <= arr.lookup_addr[2] ? lk_beat[63:32] : lk_beat[31:0];
		end
		if (arr.fill_req) begin
			data_mem[fl_idx][fl_way][arr.fill_beat] <= arr.fill_data;
			if (arr.fill_beat == '0) begin
				tag_mem[fl_idx][fl_way] <= arr.fill_addr[31 -: TAG_BITS];
			end
		end
		// Write-through never allocates, a missing line is left alone
		if (arr.store_req && (|st_match)) begin
			for (int b = 0; b < 8; b++) begin
				if (st_be[b]) begin
					data_mem[st_idx][st_way][st_beat][b*8 +: 8] <= st_wide[b*8 +: 8];
				end
			end
		end
	end

	// Lookups only come from an idle controller, never during a refill
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		arr.lookup_req |-> !(arr.state inside {REFILL_REQ, REFILL_GET}))
		else $error("lookup accepted during line fill");

endmodule

// File: hdl/l1_data_cache.sv
`timescale 1ns/10ps

module l1_data_cache
	import dcache_pkg::*;
#(
	parameter int CACHE_ENABLE = 1
) (
	input	logic			iCLOCK,
	input	logic			inRESET,
	input	logic			flush,
	dcache_ldst_if.cache	ldst,
	dcache_array_if.ctrl	arr,
	// Memory bus
	output	logic			mem_req,
	output	logic			mem_rw,
	output	access_order_t	mem_order,
	output	logic [31:0]	mem_addr,
	output	logic [31:0]	mem_wdata,
	input	logic			mem_lock,
	input	logic			mem_valid,
	input	logic [63:0]	mem_rdata
);

	// Whole line when caching, single beat otherwise
	localparam logic [BEAT_BITS:0] RD_BEATS =
		(CACHE_ENABLE != 0) ? (BEAT_BITS + 1)'(LINE_BEATS) : (BEAT_BITS + 1)'(1);

	ctrl_state_t			state;
	logic [BEAT_BITS:0]		req_cnt;
	logic [BEAT_BITS:0]		get_cnt;
	logic [31:0]			req_addr;
	access_order_t			req_order;
	logic [31:0]			req_wdata;
	logic [31:0]			rd_word;
	logic					accept;
	logic					refilling;
	logic					beat_in;
	logic [31:0]			refill_addr;
	logic [31:0]			beat_word;

	assign accept		= (state == IDLE) && ldst.req;
	assign refilling	= (state == REFILL_REQ) || (state == REFILL_GET);
	assign beat_in		= refilling && mem_valid && (get_cnt != RD_BEATS);
	assign beat_word	= req_addr[2] ? mem_rdata[63:32] : mem_rdata[31:0];
	assign refill_addr	= (CACHE_ENABLE != 0) ?
		{req_addr[31:OFFSET_BITS], req_cnt[BEAT_BITS-1:0], 3'b000} :
		{req_addr[31:3], 3'b000};

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state	<= IDLE;
			req_cnt	<= '0;
			get_cnt	<= '0;
		end else begin
			// Returned beats are counted while requests are still going out
			if (beat_in) begin
				get_cnt <= get_cnt + 1'b1;
			end
			case (state)
				IDLE: begin
					if (accept) begin
						if (!ldst.rw) begin
							state <= WR_REQ;
						end else if (CACHE_ENABLE != 0) begin
							state <= LOOKUP;
						end else begin
							state <= REFILL_REQ;
						end
					end
				end
				LOOKUP: begin
					if (arr.lookup_valid) begin
						state <= arr.lookup_hit ? RD_OUT : REFILL_REQ;
					end
				end
				REFILL_REQ: begin
					if (!mem_lock) begin
						if (req_cnt == RD_BEATS - 1'b1) begin
							req_cnt	<= '0;
							state	<= REFILL_GET;
						end else begin
							req_cnt <= req_cnt + 1'b1;
						end
					end
				end
				REFILL_GET: begin
					if (get_cnt == RD_BEATS) begin
						get_cnt	<= '0;
						state	<= RD_OUT;
					end
				end
				WR_REQ: begin
					if (!mem_lock) begin
						state <= WR_WAIT;
					end
				end
				WR_WAIT: begin
					if (mem_valid) begin
						state <= WR_OUT;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			req_addr	<= ldst.addr;
			req_order	<= ldst.order;
			req_wdata	<= ldst.wdata;
		end
		if ((state == LOOKUP) && arr.lookup_valid) begin
			rd_word <= arr.lookup_data;
		end
		// Requested word picked off the burst on its way into the array
		if (beat_in && ((CACHE_ENABLE == 0) ||
				(get_cnt[BEAT_BITS-1:0] == req_addr[OFFSET_BITS-1:3]))) begin
			rd_word <= beat_word;
		end
	end

	assign mem_req		= (state == REFILL_REQ) || (state == WR_REQ);
	assign mem_rw		= (state == REFILL_REQ);
	assign mem_order	= (state == WR_REQ) ? req_order : ORDER_WORD;
	assign mem_addr		= (state == WR_REQ) ? req_addr : refill_addr;
	assign mem_wdata	= req_wdata;

	assign arr.state		= state;
	assign arr.lookup_req	= accept && ldst.rw && (CACHE_ENABLE != 0);
	assign arr.lookup_addr	= ldst.addr;
	assign arr.fill_req		= beat_in && (CACHE_ENABLE != 0);
	assign arr.fill_addr	= req_addr;
	assign arr.fill_beat	= get_cnt[BEAT_BITS-1:0];
	assign arr.fill_data	= mem_rdata;
	assign arr.store_req	= (state == WR_REQ) && !mem_lock && (CACHE_ENABLE != 0);
	assign arr.store_addr	= req_addr;
	assign arr.store_order	= req_order;
	assign arr.store_data	= req_wdata;
	assign arr.flush		= flush;

	assign ldst.busy	= (state != IDLE);
	assign ldst.valid	= (state == RD_OUT) || (state == WR_OUT);
	assign ldst.rdata	= rd_word;

	// Memory traffic starts only from an accepted request or a lookup miss
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		$rose(mem_req) |-> $past(accept) || $past((state == LOOKUP) && !arr.lookup_hit))
		else $error("mem_req raised from IDLE without a request");

	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(get_cnt <= LINE_BEATS) && (req_cnt < LINE_BEATS))
		else $error("refill beat counter out of range");

endmodule

// File: hdl/dcache_subsystem.sv
`timescale 1ns/10ps

module dcache_subsystem
	import dcache_pkg::*;
#(
	parameter int NUM_SETS		= 16,
	parameter int CACHE_ENABLE	= 1
) (
	input	logic			iCLOCK,
	input	logic			inRESET,
	input	logic			flush,
	input	logic			iosr_valid,
	input	logic [31:0]	iosr_base,
	// Load/store unit
	input	logic			ldst_req,
	input	logic			ldst_rw,
	input	access_order_t	ldst_order,
	input	logic [31:0]	ldst_addr,
	input	logic [31:0]	ldst_wdata,
	output	logic			ldst_busy,
	output	logic			ldst_valid,
	output	logic [31:0]	ldst_rdata,
	// Memory bus
	output	logic			mem_req,
	output	logic			mem_rw,
	output	access_order_t	mem_order,
	output	logic [31:0]	mem_addr,
	output	logic [31:0]	mem_wdata,
	input	logic			mem_lock,
	input	logic			mem_valid,
	input	logic [63:0]	mem_rdata,
	// I/O bus
	output	logic			io_req,
	output	logic			io_rw,
	output	access_order_t	io_order,
	output	logic [31:0]	io_addr,
	output	logic [31:0]	io_wdata,
	input	logic			io_busy,
	input	logic			io_valid,
	input	logic [31:0]	io_rdata
);

	dcache_ldst_if	ldst_bus ();
	dcache_array_if	arr_bus ();

	io_window_router u_router (
		.iCLOCK		(iCLOCK),
		.inRESET	(inRESET),
		.iosr_valid	(iosr_valid),
		.iosr_base	(iosr_base),
		.ldst_req	(ldst_req),
		.ldst_rw	(ldst_rw),
		.ldst_order	(ldst_order),
		.ldst_addr	(ldst_addr),
		.ldst_wdata	(ldst_wdata),
		.ldst_busy	(ldst_busy),
		.ldst_valid	(ldst_valid),
		.ldst_rdata	(ldst_rdata),
		.io_req		(io_req),
		.io_rw		(io_rw),
		.io_order	(io_order),
		.io_addr	(io_addr),
		.io_wdata	(io_wdata),
		.io_busy	(io_busy),
		.io_valid	(io_valid),
		.io_rdata	(io_rdata),
		.cache		(ldst_bus.router)
	);

	l1_data_cache #(
		.CACHE_ENABLE	(CACHE_ENABLE)
	) u_ctrl (
		.iCLOCK		(iCLOCK),
		.inRESET	(inRESET),
		.flush		(flush),
		.ldst		(ldst_bus.cache),
		.arr		(arr_bus.ctrl),
		.mem_req	(mem_req),
		.mem_rw		(mem_rw),
		.mem_order	(mem_order),
		.mem_addr	(mem_addr),
		.mem_wdata	(mem_wdata),
		.mem_lock	(mem_lock),
		.mem_valid	(mem_valid),
		.mem_rdata	(mem_rdata)
	);

	dcache_array #(
		.NUM_SETS	(NUM_SETS)
	) u_array (
		.iCLOCK		(iCLOCK),
		.inRESET	(inRESET),
		.arr		(arr_bus.array)
	);

endmodule

// File: dv/tb_mem_model.sv
`timescale 1ns/10ps

module tb_mem_model
	import dcache_pkg::*;
(
	input	logic			iCLOCK,
	input	logic			inRESET,
	input	logic			stall_en,
	// Memory bus
	input	logic			mem_req,
	input	logic			mem_rw,
	input	access_order_t	mem_order,
	input	logic [31:0]	mem_addr,
	input	logic [31:0]	mem_wdata,
	output	logic			mem_lock,
	output	logic			mem_valid,
	output	logic [63:0]	mem_rdata,
	// I/O bus
	input	logic			io_req,
	input	logic			io_rw,
	input	access_order_t	io_order,
	input	logic [31:0]	io_addr,
	input	logic [31:0]	io_wdata,
	output	logic			io_busy,
	output	logic			io_valid,
	output	logic [31:0]	io_rdata,
	// Traffic seen so far
	output	int				mem_takes,
	output	int				io_takes,
	output	logic			last_mem_rw,
	output	access_order_t	last_mem_order,
	output	logic [31:0]	last_mem_addr,
	output	logic [31:0]	last_mem_wdata,
	output	logic			last_io_rw,
	output	access_order_t	last_io_order,
	output	logic [31:0]	last_io_addr,
	output	logic [31:0]	last_io_wdata
);

	logic [31:0]	words [logic [29:0]];
	logic [31:0]	rsp_q [$];
	logic [31:0]	io_q [$];
	logic [31:0]	rng;
	logic [31:0]	beat_addr;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Unwritten words follow the address pattern
	function automatic logic [31:0] read_word(input logic [31:0] a);
		if (words.exists(a[31:2])) begin
			return words[a[31:2]];
		end
		return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
	endfunction

	task automatic store_write(input logic [31:0] a, input access_order_t ord,
			input logic [31:0] d);
		logic [31:0] w;
		w = read_word(a);
		case (ord)
			ORDER_BYTE: w[a[1:0]*8 +: 8] = d[7:0];
			ORDER_HALF: w[a[1]*16 +: 16] = d[15:0];
			default: w = d;
		endcase
		words[a[31:2]] = w;
	endtask

	initial begin
		mem_lock		= 1'b0;
		mem_valid		= 1'b0;
		mem_rdata		= '0;
		io_busy			= 1'b0;
		io_valid		= 1'b0;
		io_rdata		= '0;
		mem_takes		= 0;
		io_takes		= 0;
		last_mem_rw		= 1'b0;
		last_mem_order	= ORDER_WORD;
		last_mem_addr	= '0;
		last_mem_wdata	= '0;
		last_io_rw		= 1'b0;
		last_io_order	= ORDER_WORD;
		last_io_addr	= '0;
		last_io_wdata	= '0;
		rng				= 32'h9c87_5fb9;
	end

	always @(negedge iCLOCK) begin
		if (!inRESET) begin
			words.delete();
			rsp_q.delete();
			io_q.delete();
			mem_lock	= 1'b0;
			mem_valid	= 1'b0;
			io_busy		= 1'b0;
			io_valid	= 1'b0;
		end else begin
			rng			= xorshift(rng);
			mem_lock	= stall_en && (rng[1:0] == 2'b00);
			io_busy		= stall_en && (rng[9:8] == 2'b00);
			// Answer earlier beats in order, sometimes with a gap
			mem_valid = 1'b0;
			if ((rsp_q.size() != 0) && !(stall_en && rng[17])) begin
				beat_addr	= rsp_q.pop_front();
				mem_valid	= 1'b1;
				mem_rdata	= {read_word(beat_addr + 32'd4), read_word(beat_addr)};
			end
			io_valid = 1'b0;
			if ((io_q.size() != 0) && !(stall_en && rng[21])) begin
				io_valid	= 1'b1;
				io_rdata	= io_q.pop_front() ^ 32'h1111_1111;
			end
			// Requests settle, then whatever the next edge takes is logged
			#2;
			if (mem_req && !mem_lock) begin
				mem_takes		= mem_takes + 1;
				last_mem_rw		= mem_rw;
				last_mem_order	= mem_order;
				last_mem_addr	= mem_addr;
				last_mem_wdata	= mem_wdata;
				if (!mem_rw) begin
					store_write(mem_addr, mem_order, mem_wdata);
				end
				rsp_q.push_back({mem_addr[31:3], 3'b000});
			end
			if (io_req && !io_busy) begin
				io_takes		= io_takes + 1;
				last_io_rw		= io_rw;
				last_io_order	= io_order;
				last_io_addr	= io_addr;
				last_io_wdata	= io_wdata;
				io_q.push_back(io_addr);
			end
		end
	end

endmodule

// File: dv/tb_dcache.sv
`timescale 1ns/10ps

module tb_dcache
	import dcache_pkg::*;
();

	localparam int			TIMEOUT		= 200;
	localparam logic [31:0]	LINE_A		= 32'h0000_1000;
	localparam logic [31:0]	SET_B		= 32'h0000_20c0;
	localparam logic [31:0]	SET_STRIDE	= 32'h0000_0400;
	localparam logic [31:0]	IO_BASE		= 32'h8000_0000;

	typedef enum logic [1:0] {
		OP_READ,
		OP_WRITE,
		OP_FLUSH,
		OP_BASE
	} op_t;

	typedef struct packed {
		op_t			op;
		logic [31:0]	addr;
		access_order_t	order;
		logic [31:0]	wdata;
		logic [31:0]	exp_data;
		logic [3:0]		exp_mem;
		logic [1:0]		exp_io;
	} step_t;

	logic			iCLOCK;
	logic			inRESET;
	logic			flush;
	logic			iosr_valid;
	logic [31:0]	iosr_base;
	logic			ldst_req;
	logic			ldst_rw;
	access_order_t	ldst_order;
	logic [31:0]	ldst_addr;
	logic [31:0]	ldst_wdata;
	logic			ldst_busy;
	logic			ldst_valid;
	logic [31:0]	ldst_rdata;
	logic			mem_req;
	logic			mem_rw;
	access_order_t	mem_order;
	logic [31:0]	mem_addr;
	logic [31:0]	mem_wdata;
	logic			mem_lock;
	logic			mem_valid;
	logic [63:0]	mem_rdata;
	logic			io_req;
	logic			io_rw;
	access_order_t	io_order;
	logic [31:0]	io_addr;
	logic [31:0]	io_wdata;
	logic			io_busy;
	logic			io_valid;
	logic [31:0]	io_rdata;
	logic			stall_en;
	int				mem_takes;
	int				io_takes;
	logic			last_mem_rw;
	access_order_t	last_mem_order;
	logic [31:0]	last_mem_addr;
	logic [31:0]	last_mem_wdata;
	logic			last_io_rw;
	access_order_t	last_io_order;
	logic [31:0]	last_io_addr;
	logic [31:0]	last_io_wdata;

	step_t			steps [$];
	int				mismatches;
	int				timeouts;
	int				cur_step;
	logic			aborted;
	logic [31:0]	io_base;

	dcache_subsystem #(
		.NUM_SETS		(16),
		.CACHE_ENABLE	(1)
	) UUT (
		.iCLOCK		(iCLOCK),
		.inRESET	(inRESET),
		.flush		(flush),
		.iosr_valid	(iosr_valid),
		.iosr_base	(iosr_base),
		.ldst_req	(ldst_req),
		.ldst_rw	(ldst_rw),
		.ldst_order	(ldst_order),
		.ldst_addr	(ldst_addr),
		.ldst_wdata	(ldst_wdata),
		.ldst_busy	(ldst_busy),
		.ldst_valid	(ldst_valid),
		.ldst_rdata	(ldst_rdata),
		.mem_req	(mem_req),
		.mem_rw		(mem_rw),
		.mem_order	(mem_order),
		.mem_addr	(mem_addr),
		.mem_wdata	(mem_wdata),
		.mem_lock	(mem_lock),
		.mem_valid	(mem_valid),
		.mem_rdata	(mem_rdata),
		.io_req		(io_req),
		.io_rw		(io_rw),
		.io_order	(io_order),
		.io_addr	(io_addr),
		.io_wdata	(io_wdata),
		.io_busy	(io_busy),
		.io_valid	(io_valid),
		.io_rdata	(io_rdata)
	);

	tb_mem_model mem_model (
		.iCLOCK			(iCLOCK),
		.inRESET		(inRESET),
		.stall_en		(stall_en),
		.mem_req		(mem_req),
		.mem_rw			(mem_rw),
		.mem_order		(mem_order),
		.mem_addr		(mem_addr),
		.mem_wdata		(mem_wdata),
		.mem_lock		(mem_lock),
		.mem_valid		(mem_valid),
		.mem_rdata		(mem_rdata),
		.io_req			(io_req),
		.io_rw			(io_rw),
		.io_order		(io_order),
		.io_addr		(io_addr),
		.io_wdata		(io_wdata),
		.io_busy		(io_busy),
		.io_valid		(io_valid),
		.io_rdata		(io_rdata),
		.mem_takes		(mem_takes),
		.io_takes		(io_takes),
		.last_mem_rw	(last_mem_rw),
		.last_mem_order	(last_mem_order),
		.last_mem_addr	(last_mem_addr),
		.last_mem_wdata	(last_mem_wdata),
		.last_io_rw		(last_io_rw),
		.last_io_order	(last_io_order),
		.last_io_addr	(last_io_addr),
		.last_io_wdata	(last_io_wdata)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #50 iCLOCK = ~iCLOCK;
	end

	// Memory contents before any write
	function automatic logic [31:0] mem_word(input logic [31:0] a);
		return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("ERROR %s: got %h, expected %h at step %0d", name, got, exp, cur_step);
		end
	endtask

	task automatic add_step(input op_t op, input logic [31:0] addr, input access_order_t order,
			input logic [31:0] wdata, input logic [31:0] exp_data, input int exp_mem,
			input int exp_io);
		steps.push_back('{op, addr, order, wdata, exp_data, 4'(exp_mem), 2'(exp_io)});
	endtask

	task automatic build_table();
		logic [31:0] merged_half;
		logic [31:0] merged_byte;
		merged_half			= mem_word(LINE_A + 32'h4);
		merged_half[31:16]	= 16'hbeef;
		merged_byte			= mem_word(LINE_A + 32'h8);
		merged_byte[15:8]	= 8'ha5;
		// One refill, then hits on the same line
		add_step(OP_READ, LINE_A + 32'h8, ORDER_WORD, '0, mem_word(LINE_A + 32'h8), 8, 0);
		add_step(OP_READ, LINE_A + 32'h8, ORDER_WORD, '0, mem_word(LINE_A + 32'h8), 0, 0);
		add_step(OP_READ, LINE_A + 32'h3c, ORDER_WORD, '0, mem_word(LINE_A + 32'h3c), 0, 0);
		// Write-through updates the cached copy in place
		add_step(OP_WRITE, LINE_A, ORDER_WORD, 32'h1234_5678, '0, 1, 0);
		add_step(OP_READ, LINE_A, ORDER_WORD, '0, 32'h1234_5678, 0, 0);
		add_step(OP_WRITE, LINE_A + 32'h6, ORDER_HALF, 32'h0000_beef, '0, 1, 0);
		add_step(OP_READ, LINE_A + 32'h4, ORDER_WORD, '0, merged_half, 0, 0);
		add_step(OP_WRITE, LINE_A + 32'h9, ORDER_BYTE, 32'h0000_00a5, '0, 1, 0);
		add_step(OP_READ, LINE_A + 32'h8, ORDER_WORD, '0, merged_byte, 0, 0);
		// Five lines in one set; the fifth evicts way 0, so the first refills
		for (int k = 0; k < 5; k++) begin
			add_step(OP_READ, SET_B + k * SET_STRIDE, ORDER_WORD, '0,
				mem_word(SET_B + k * SET_STRIDE), 8, 0);
		end
		add_step(OP_READ, SET_B, ORDER_WORD, '0, mem_word(SET_B), 8, 0);
		add_step(OP_READ, SET_B + 4 * SET_STRIDE, ORDER_WORD, '0,
			mem_word(SET_B + 4 * SET_STRIDE), 0, 0);
		// No window yet, then the same address goes to I/O
		add_step(OP_READ, IO_BASE + 32'h10, ORDER_WORD, '0, mem_word(IO_BASE + 32'h10), 8, 0);
		add_step(OP_BASE, IO_BASE, ORDER_WORD, '0, '0, 0, 0);
		add_step(OP_READ, IO_BASE + 32'h10, ORDER_WORD, '0, 32'h10 ^ 32'h1111_1111, 0, 1);
		add_step(OP_WRITE, IO_BASE + 32'h24, ORDER_WORD, 32'hcafe_0001, '0, 0, 1);
		add_step(OP_READ, LINE_A + 32'h8, ORDER_WORD, '0, merged_byte, 0, 0);
		// Flush forces a refill of data written earlier
		add_step(OP_FLUSH, '0, ORDER_WORD, '0, '0, 0, 0);
		add_step(OP_READ, LINE_A, ORDER_WORD, '0, 32'h1234_5678, 8, 0);
		add_step(OP_READ, LINE_A + 32'h4, ORDER_WORD, '0, merged_half, 0, 0);
	endtask

	task automatic apply_reset(input logic stalls);
		@(negedge iCLOCK);
		stall_en	= stalls;
		inRESET		= 1'b0;
		repeat (10) @(negedge iCLOCK);
		inRESET		= 1'b1;
	endtask

	// Ends on the falling edge after the accepting edge
	task automatic wait_accept(output logic ok);
		int		n;
		logic	busy;
		ok	= 1'b0;
		n	= 0;
		while (!ok && (n < TIMEOUT)) begin
			#1;
			busy = ldst_busy;
			@(posedge iCLOCK);
			ok = !busy;
			@(negedge iCLOCK);
			n++;
		end
		if (!ok) begin
			timeouts++;
			$display("Timeout: request of step %0d was never accepted", cur_step);
		end
	endtask

	// Latency counts clock edges from acceptance to the valid pulse
	task automatic wait_valid(output int lat, output logic ok);
		ok	= 1'b0;
		lat	= 0;
		while (!ok && (lat < TIMEOUT)) begin
			#1;
			lat++;
			check_value("ldst_busy", ldst_busy, 1'b1);
			if (ldst_valid) begin
				ok = 1'b1;
			end else begin
				@(negedge iCLOCK);
			end
		end
		if (!ok) begin
			timeouts++;
			$display("Timeout: no response for step %0d", cur_step);
		end
	endtask

	task automatic run_step(input int i);
		step_t	s;
		int		mem0;
		int		io0;
		int		lat;
		logic	ok;
		s			= steps[i];
		cur_step	= i;
		mem0		= mem_takes;
		io0			= io_takes;
		case (s.op)
			OP_FLUSH: begin
				@(negedge iCLOCK);
				flush = 1'b1;
				@(negedge iCLOCK);
				flush = 1'b0;
			end
			OP_BASE: begin
				@(negedge iCLOCK);
				iosr_valid	= 1'b1;
				iosr_base	= s.addr;
				io_base		= s.addr;
				@(negedge iCLOCK);
				iosr_valid	= 1'b0;
			end
			default: begin
				@(negedge iCLOCK);
				ldst_req	= 1'b1;
				ldst_rw		= (s.op == OP_READ);
				ldst_order	= s.order;
				ldst_addr	= s.addr;
				ldst_wdata	= s.wdata;
				wait_accept(ok);
				ldst_req = 1'b0;
				if (ok) begin
					wait_valid(lat, ok);
				end
				if (!ok) begin
					aborted = 1'b1;
				end else begin
					if (s.op == OP_READ) begin
						check_value("ldst_rdata", ldst_rdata, s.exp_data);
					end
					check_value("mem_req beats", mem_takes - mem0, s.exp_mem);
					check_value("io_req count", io_takes - io0, s.exp_io);
					if ((s.op == OP_READ) && (s.exp_mem == 0) && (s.exp_io == 0)) begin
						check_value("hit latency", lat, 2);
					end
					// Last refill beat carries the top of the line
					if ((s.op == OP_READ) && (s.exp_mem == 8)) begin
						check_value("mem_addr", last_mem_addr, {s.addr[31:6], 6'h38});
						check_value("mem_rw", last_mem_rw, 1'b1);
					end
					if ((s.op == OP_WRITE) && (s.exp_mem == 1)) begin
						check_value("mem_addr", last_mem_addr, s.addr);
						check_value("mem_wdata", last_mem_wdata, s.wdata);
						check_value("mem_rw", last_mem_rw, 1'b0);
						check_value("mem_order", last_mem_order, s.order);
					end
					if (s.exp_io == 1) begin
						check_value("io_addr", last_io_addr, s.addr - io_base);
						check_value("io_rw", last_io_rw, (s.op == OP_READ));
						check_value("io_order", last_io_order, s.order);
						if (s.op == OP_WRITE) begin
							check_value("io_wdata", last_io_wdata, s.wdata);
						end
					end
					@(negedge iCLOCK);
					#1;
					check_value("ldst_valid", ldst_valid, 1'b0);
				end
			end
		endcase
	endtask

	initial begin
		inRESET		= 1'b0;
		flush		= 1'b0;
		iosr_valid	= 1'b0;
		iosr_base	= '0;
		ldst_req	= 1'b0;
		ldst_rw		= 1'b0;
		ldst_order	= ORDER_WORD;
		ldst_addr	= '0;
		ldst_wdata	= '0;
		stall_en	= 1'b0;
		mismatches	= 0;
		timeouts	= 0;
		cur_step	= 0;
		aborted		= 1'b0;
		io_base		= '0;
		build_table();
		// Second pass repeats the table under random lock and busy
		for (int pass = 0; (pass < 2) && !aborted; pass++) begin
			apply_reset(pass == 1);
			for (int i = 0; (i < steps.size()) && !aborted; i++) begin
				run_step(i);
			end
		end
		$display("Closing report: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if ((mismatches == 0) && (timeouts == 0)) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
hdl/dcache_pkg.sv
hdl/dcache_ldst_if.sv
hdl/dcache_array_if.sv
hdl/io_window_router.sv
hdl/dcache_array.sv
hdl/l1_data_cache.sv
hdl/dcache_subsystem.sv
dv/tb_mem_model.sv
dv/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache_subsystem

sources:
  - files:
      - hdl/dcache_pkg.sv
      - hdl/dcache_ldst_if.sv
      - hdl/dcache_array_if.sv
      - hdl/io_window_router.sv
      - hdl/dcache_array.sv
      - hdl/l1_data_cache.sv
      - hdl/dcache_subsystem.sv
  - target: test
    files:
      - dv/tb_mem_model.sv
      - dv/tb_dcache.sv
